/* source/arith_ctrl_pkg.sv */
// arithmetic unit control types

package arith_ctrl_pkg;

    // operation code as seen on op_code
    typedef enum logic [1:0] {
        op_add  = 2'b00,
        op_sub  = 2'b01,
        op_mul  = 2'b10,
        op_rsvd = 2'b11  // ignored by an idle unit
    } opcode_t;

    // sequencer states
    typedef enum logic [3:0] {
        st_idle,
        st_load_a,   // first word into A
        st_load_q,   // first word into Q, A and Q[-1] cleared
        st_load_m,   // second word into M
        st_add_m,    // A gets the adder result
        st_shift_1,  // first arithmetic right shift
        st_shift_2,  // second arithmetic right shift
        st_count,    // next radix-4 step
        st_push_a,   // low word of A to the bus
        st_push_q    // Q to the bus
    } ctrl_state_t;

    // what the adder adds to A
    typedef enum logic [1:0] {
        fn_add,   // +M
        fn_sub,   // -M
        fn_booth  // +-M or +-2M from the recoded Q bits
    } alu_func_t;

    typedef logic [3:0] credit_t;  // output credits held

endpackage

/* source/arith_data_pkg.sv */
// arithmetic unit data types

package arith_data_pkg;

    localparam int word_width = 8;  // operand and result width

    // one word on in_data or out_data
    typedef logic [word_width-1:0] word_t;

    // accumulator A, one guard bit above the word
    typedef logic [word_width:0] acc_t;

    // radix-4 retires two multiplier bits per step
    localparam int booth_iters = word_width / 2;

    // counts finished booth steps
    typedef logic [2:0] iter_t;

endpackage

/* source/arith_datapath.sv */
// accumulator datapath with booth recoder

`timescale 1ns/1ps

module arith_datapath (
    input  logic                      clk,
    input  logic                      rst,
    input  arith_data_pkg::word_t     in_data,
    input  logic                      load_a,
    input  logic                      load_q,
    input  logic                      load_m,
    input  logic                      clear_acc,
    input  logic                      add_en,
    input  logic                      shift_en,
    input  logic                      push_a,
    input  logic                      push_q,
    input  arith_ctrl_pkg::alu_func_t func,
    output logic                      booth_nonzero,
    output arith_data_pkg::word_t     out_data
);

    import arith_ctrl_pkg::*;
    import arith_data_pkg::*;

    acc_t  acc;          // register A
    logic  acc_sign;     // true sign of A, survives a 2M add past the guard bit
    word_t q_reg;        // register Q, multiplier then low product
    logic  q_m1;         // Q[-1]
    word_t m_reg;        // register M

    logic [2:0] booth_bits;  // Q[1], Q[0], Q[-1]
    acc_t  m_ext;            // M sign extended
    acc_t  m_dbl;            // 2M
    acc_t  addend;
    logic  negate;           // subtract the addend

    logic [word_width+1:0] addend_ext;
    logic [word_width+1:0] operand_b;
    logic [word_width+1:0] sum_full;   // A plus operand, no overflow

    assign booth_bits = {q_reg[1:0], q_m1};
    assign booth_nonzero = (booth_bits != 3'b000) && (booth_bits != 3'b111);

    assign m_ext = {m_reg[word_width-1], m_reg};
    assign m_dbl = {m_reg, 1'b0};  // still fits in the guard bit

    // pick the magnitude and direction of the add
    always_comb begin
        addend = '0;
        negate = 1'b0;
        case (func)
            fn_add: begin
                addend = m_ext;
            end
            fn_sub: begin
                addend = m_ext;
                negate = 1'b1;
            end
            fn_booth: begin
                case (booth_bits)
                    3'b001, 3'b010: begin
                        addend = m_ext;  // +M
                    end
                    3'b011: begin
                        addend = m_dbl;  // +2M
                    end
                    3'b100: begin
                        addend = m_dbl;  // -2M
                        negate = 1'b1;
                    end
                    3'b101, 3'b110: begin
                        addend = m_ext;  // -M
                        negate = 1'b1;
                    end
                    default: begin
                        addend = '0;     // run of equal bits
                    end
                endcase
            end
            default: begin
                addend = '0;
            end
        endcase
    end

    // two's complement subtract by invert and carry in
    assign addend_ext = {addend[word_width], addend};
    assign operand_b  = negate ? ~addend_ext : addend_ext;
    assign sum_full   = {acc_sign, acc} + operand_b + {{(word_width + 1){1'b0}}, negate};

    // A and Q[-1]
    always_ff @(posedge clk) begin
        if (rst || clear_acc) begin
            acc      <= '0;
            acc_sign <= 1'b0;
            q_m1     <= 1'b0;
        end else if (load_a) begin
            acc      <= {in_data[word_width-1], in_data};
            acc_sign <= in_data[word_width-1];
        end else if (add_en) begin
            acc      <= sum_full[word_width:0];
            acc_sign <= sum_full[word_width+1];
        end else if (shift_en) begin
            acc  <= {acc_sign, acc[word_width:1]};  // arithmetic shift, sign kept
            q_m1 <= q_reg[0];
        end
    end

    // Q takes the bit falling out of A
    always_ff @(posedge clk) begin
        if (load_q) begin
            q_reg <= in_data;
        end else if (shift_en) begin
            q_reg <= {acc[0], q_reg[word_width-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (load_m) begin
            m_reg <= in_data;
        end
    end

    // result word onto the bus
    always_comb begin
        if (push_a) begin
            out_data = acc[word_width-1:0];  // sum, difference or high product
        end else if (push_q) begin
            out_data = q_reg;                // low product
        end else begin
            out_data = '0;
        end
    end

endmodule

/* source/arith_unit_top.sv */
// sequential arithmetic unit

`timescale 1ns/1ps

module arith_unit_top #(
    parameter int out_credits = 2  // consumer buffer depth
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  arith_ctrl_pkg::opcode_t op_code,
    input  arith_data_pkg::word_t   in_data,    // operand words, start cycle first
    output arith_data_pkg::word_t   out_data,
    output logic                    out_valid,
    input  logic                    out_credit,
    output logic                    done,
    output logic                    busy
);

    import arith_ctrl_pkg::*;

    // sequencer to datapath
    logic      load_a;
    logic      load_q;
    logic      load_m;
    logic      clear_acc;
    logic      add_en;
    logic      shift_en;
    logic      push_a;
    logic      push_q;
    alu_func_t func;

    logic booth_nonzero;  // datapath to sequencer
    logic credit_avail;   // tracker to sequencer

    booth_control u_control (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .op_code       (op_code),
        .booth_nonzero (booth_nonzero),
        .credit_avail  (credit_avail),
        .load_a        (load_a),
        .load_q        (load_q),
        .load_m        (load_m),
        .clear_acc     (clear_acc),
        .add_en        (add_en),
        .shift_en      (shift_en),
        .push_a        (push_a),
        .push_q        (push_q),
        .func          (func),
        .out_valid     (out_valid),
        .done          (done),
        .busy          (busy)
    );

    arith_datapath u_datapath (
        .clk           (clk),
        .rst           (rst),
        .in_data       (in_data),
        .load_a        (load_a),
        .load_q        (load_q),
        .load_m        (load_m),
        .clear_acc     (clear_acc),
        .add_en        (add_en),
        .shift_en      (shift_en),
        .push_a        (push_a),
        .push_q        (push_q),
        .func          (func),
        .booth_nonzero (booth_nonzero),
        .out_data      (out_data)
    );

    out_credit_tracker #(
        .out_credits (out_credits)
    ) u_credits (
        .clk          (clk),
        .rst          (rst),
        .out_valid    (out_valid),
        .out_credit   (out_credit),
        .credit_avail (credit_avail)
    );

endmodule

/* source/booth_control.sv */
// operation sequencer

`timescale 1ns/1ps

module booth_control (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,          // sampled in idle only
    input  arith_ctrl_pkg::opcode_t   op_code,
    input  logic                      booth_nonzero,  // low when no add is needed
    input  logic                      credit_avail,   // consumer can take a word
    output logic                      load_a,
    output logic                      load_q,
    output logic                      load_m,
    output logic                      clear_acc,
    output logic                      add_en,
    output logic                      shift_en,
    output logic                      push_a,
    output logic                      push_q,
    output arith_ctrl_pkg::alu_func_t func,
    output logic                      out_valid,
    output logic                      done,
    output logic                      busy
);

    import arith_ctrl_pkg::*;
    import arith_data_pkg::*;

    ctrl_state_t state;       // registered state
    ctrl_state_t act_state;   // state acting in this cycle
    ctrl_state_t next_state;
    opcode_t     op_q;        // opcode latched at start
    iter_t       iter;        // finished booth steps
    logic        accept;      // legal start seen in idle
    logic        is_mul;
    logic        last_iter;

    // reserved opcode never leaves idle
    assign accept = (state == st_idle) && start && (op_code != op_rsvd);

    // the start cycle already loads the first word
    // so idle acts as a load state when a start is accepted
    always_comb begin
        act_state = state;
        if (accept) begin
            if (op_code == op_mul) begin
                act_state = st_load_q;
            end else begin
                act_state = st_load_a;
            end
        end
    end

    assign is_mul    = (op_q == op_mul);
    assign last_iter = (iter == iter_t'(booth_iters - 1));  // fourth step

    always_comb begin
        next_state = act_state;
        case (act_state)
            st_idle: begin
                next_state = st_idle;
            end
            st_load_a, st_load_q: begin
                next_state = st_load_m;  // second word follows right away
            end
            st_load_m: begin
                if (is_mul && !booth_nonzero) begin
                    next_state = st_shift_1;  // recoded digit is zero
                end else begin
                    next_state = st_add_m;
                end
            end
            st_add_m: begin
                next_state = is_mul ? st_shift_1 : st_push_a;
            end
            st_shift_1: begin
                next_state = st_shift_2;
            end
            st_shift_2: begin
                next_state = last_iter ? st_push_a : st_count;
            end
            st_count: begin
                // Q already holds the next bit triple
                next_state = booth_nonzero ? st_add_m : st_shift_1;
            end
            st_push_a: begin
                if (credit_avail) begin
                    next_state = is_mul ? st_push_q : st_idle;
                end
            end
            st_push_q: begin
                if (credit_avail) begin
                    next_state = st_idle;
                end
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            op_q  <= op_add;
            iter  <= '0;
        end else begin
            state <= next_state;
            if (accept) begin
                op_q <= op_code;
            end
            if (act_state == st_load_m) begin
                iter <= '0;  // fresh count per operation
            end else if (act_state == st_count) begin
                iter <= iter + iter_t'(1);
            end
        end
    end

    // datapath strobes, one per acting state
    assign load_a    = (act_state == st_load_a);
    assign load_q    = (act_state == st_load_q);
    assign clear_acc = (act_state == st_load_q);  // mul starts from A = 0, Q[-1] = 0
    assign load_m    = (act_state == st_load_m);
    assign add_en    = (act_state == st_add_m);
    assign shift_en  = (act_state == st_shift_1) || (act_state == st_shift_2);
    assign push_a    = (act_state == st_push_a);
    assign push_q    = (act_state == st_push_q);

    // adder function follows the latched opcode
    always_comb begin
        case (op_q)
            op_sub:  func = fn_sub;
            op_mul:  func = fn_booth;
            default: func = fn_add;
        endcase
    end

    assign out_valid = (push_a || push_q) && credit_avail;  // held back without credit
    assign done      = out_valid && (push_q || !is_mul);    // last word of the result
    assign busy      = (state != st_idle);

endmodule

/* source/out_credit_tracker.sv */
// output credit counter

`timescale 1ns/1ps

module out_credit_tracker #(
    parameter int out_credits = 2  // words the consumer can buffer, 1 to 15
) (
    input  logic clk,
    input  logic rst,
    input  logic out_valid,    // one word sent, one credit spent
    input  logic out_credit,   // one credit returned
    output logic credit_avail
);

    import arith_ctrl_pkg::*;

    credit_t credit_cnt;  // credits in hand

    always_ff @(posedge clk) begin
        if (rst) begin
            credit_cnt <= credit_t'(out_credits);  // consumer starts empty
        end else begin
            case ({out_valid, out_credit})
                2'b10: begin
                    credit_cnt <= credit_cnt - credit_t'(1);
                end
                2'b01: begin
                    credit_cnt <= credit_cnt + credit_t'(1);
                end
                default: begin
                    credit_cnt <= credit_cnt;  // none or both
                end
            endcase
        end
    end

    assign credit_avail = (credit_cnt != '0);

endmodule

/* test/tb_arith_unit.sv */
// arithmetic unit testbench

`timescale 1ns/1ps

module tb_arith_unit;

    import arith_ctrl_pkg::*;
    import arith_data_pkg::*;

    localparam int n_addsub   = 200;
    localparam int n_mul      = n_addsub;          // one multiply after each add or sub
    localparam int n_rsvd     = 8;                 // one every 50 legal operations
    localparam int n_ops      = n_addsub + n_mul + n_rsvd;
    localparam int max_cycles = 60 * n_ops;        // generous per-operation budget
    localparam int credits    = 2;                 // consumer buffer depth

    logic    clk;
    logic    rst;
    logic    start;
    opcode_t op_code;
    word_t   in_data;
    word_t   out_data;
    logic    out_valid;
    logic    out_credit;
    logic    done;
    logic    busy;

    logic [31:0] stim_seed;   // opcodes, operands, gaps
    logic [31:0] cons_seed;   // consumer credit delays
    int          cycle;
    int          tb_credits;  // credits the DUT should hold
    bit          started;     // first start driven
    word_t       exp_words[$];
    bit          exp_done[$];
    int          credit_due[$];  // cycle at which each held word is released

    arith_unit_top #(
        .out_credits (credits)
    ) dut (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .op_code    (op_code),
        .in_data    (in_data),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .out_credit (out_credit),
        .done       (done),
        .busy       (busy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // upper generator bits since the low bits repeat too quickly
    function automatic int stim_pick(input int n);
        stim_seed = lcg_next(stim_seed);
        return int'(stim_seed[31:16]) % n;
    endfunction

    function automatic int to_signed(input word_t w);
        return w[word_width-1] ? int'(w) - 256 : int'(w);
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic abort_run(input string why);
        $display("Error at %0t ns: %s", $time, why);
        $display("TESTS FAILED");
        $fatal(1, "run aborted");
    endtask

    // one cycle counter bounds the whole run
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle >= max_cycles) begin
            abort_run("timeout, the unit stopped producing results");
        end
    end

    // output monitor and credit-returning consumer
    always @(negedge clk) begin
        if (!rst) begin
            if (!started) begin
                check_eq(out_valid, 1'b0, "out_valid before first start");
                check_eq(done, 1'b0, "done before first start");
                check_eq(busy, 1'b0, "busy before first start");
            end
            if (done && !out_valid) begin
                abort_run("done raised without an output word");
            end
            if (out_valid) begin
                if (tb_credits == 0) begin
                    abort_run("out_valid raised while the consumer had no credit left");
                end
                if (exp_words.size() == 0) begin
                    abort_run("output word with no result pending");
                end
                check_eq(out_data, exp_words.pop_front(), "result word");
                check_eq(done, exp_done.pop_front(), "done flag");
                tb_credits = tb_credits - 1;
                cons_seed = lcg_next(cons_seed);
                credit_due.push_back(cycle + int'(cons_seed[31:16]) % 7);  // 0 to 6 cycles
            end
            // at most one credit back per cycle
            if (credit_due.size() != 0 && credit_due[0] <= cycle) begin
                void'(credit_due.pop_front());
                out_credit = 1'b1;
                tb_credits = tb_credits + 1;
            end else begin
                out_credit = 1'b0;
            end
        end
    end

    // called and left at a falling edge
    task automatic run_op(input opcode_t op, input word_t first, input word_t second);
        int          gap;
        logic [31:0] prod;
        gap = stim_pick(4);
        repeat (gap) @(negedge clk);
        while (busy) @(negedge clk);  // start only counts in idle
        case (op)
            op_add: begin
                exp_words.push_back(word_t'(int'(first) + int'(second)));
                exp_done.push_back(1'b1);
            end
            op_sub: begin
                exp_words.push_back(word_t'(int'(first) - int'(second)));
                exp_done.push_back(1'b1);
            end
            op_mul: begin
                prod = to_signed(first) * to_signed(second);  // Q times M
                exp_words.push_back(prod[15:8]);              // high word first
                exp_done.push_back(1'b0);
                exp_words.push_back(prod[7:0]);
                exp_done.push_back(1'b1);
            end
            default: begin
            end
        endcase
        started = 1'b1;
        start   = 1'b1;
        op_code = op;
        in_data = first;   // A or Q in the start cycle
        @(negedge clk);
        start   = 1'b0;
        in_data = second;  // M right after
        if (op == op_rsvd) begin
            check_eq(busy, 1'b0, "busy after reserved opcode");
        end
        @(negedge clk);
        in_data = word_t'(stim_pick(256));  // don't care from here on
    endtask

    initial begin
        word_t   a;
        word_t   b;
        opcode_t op;
        start      = 1'b0;
        op_code    = op_add;
        in_data    = '0;
        out_credit = 1'b0;
        rst        = 1'b1;
        stim_seed  = 32'd36;
        cons_seed  = lcg_next(32'd36);
        cycle      = 0;
        tb_credits = credits;
        started    = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (5) @(negedge clk);  // quiet outputs before any start

        // a short add or sub right after the two multiply words meets spent credits
        for (int i = 0; i < n_mul; i++) begin
            if (i % 25 == 12) begin
                run_op(op_rsvd, word_t'(stim_pick(256)), word_t'(stim_pick(256)));
            end
            op = (stim_pick(2) == 1) ? op_sub : op_add;
            a  = word_t'(stim_pick(256));
            b  = word_t'(stim_pick(256));
            run_op(op, a, b);
            case (i)  // corner operands around -128
                0: begin
                    a = 8'h80;
                    b = 8'h80;
                end
                1: begin
                    a = 8'h80;
                    b = 8'h7f;
                end
                2: begin
                    a = 8'h7f;
                    b = 8'h80;
                end
                3: begin
                    a = 8'h80;
                    b = 8'h00;
                end
                4: begin
                    a = 8'h00;
                    b = 8'h80;
                end
                default: begin
                    a = word_t'(stim_pick(256));
                    b = word_t'(stim_pick(256));
                end
            endcase
            run_op(op_mul, a, b);
        end

        while (exp_words.size() != 0 || busy) @(negedge clk);
        repeat (10) @(negedge clk);  // a stray word after the last result still aborts
        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* vlog.f */
source/arith_data_pkg.sv
source/arith_ctrl_pkg.sv
source/booth_control.sv
source/arith_datapath.sv
source/out_credit_tracker.sv
source/arith_unit_top.sv
test/tb_arith_unit.sv
